// ==== logic/frontend_pkg.sv ====
/*
 * Shared definitions for the dispatch front end: widths, RISC-V opcodes,
 * the instruction word union, fetch slots, micro-ops and dispatch lanes
 */
package frontend_pkg;

  localparam int FETCH_WIDTH    = 2;
  localparam int XLEN           = 32;
  localparam int REG_INDEX_BITS = 5;

  // Major opcodes accepted by the decoder
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // I-format view
  typedef struct packed {
    logic [11:0]               imm;
    logic [REG_INDEX_BITS-1:0] rs1;
    logic [2:0]                funct3;
    logic [REG_INDEX_BITS-1:0] rd;
    logic [6:0]                opcode;
  } i_form_t;

  // S-format view, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0]                imm_hi;
    logic [REG_INDEX_BITS-1:0] rs2;
    logic [REG_INDEX_BITS-1:0] rs1;
    logic [2:0]                funct3;
    logic [4:0]                imm_lo;
    logic [6:0]                opcode;
  } s_form_t;

  // One 32-bit word, read either way
  typedef union packed {
    i_form_t i_form;
    s_form_t s_form;
  } inst_word_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    inst_word_t      inst;
    logic            valid;
  } fetch_slot_t;

  typedef fetch_slot_t [FETCH_WIDTH-1:0] fetch_bundle_t;

  typedef enum logic [1:0] {
    MEM_NONE = 2'd0,
    MEM_LD   = 2'd1,
    MEM_ST   = 2'd2
  } mem_type_t;

  typedef struct packed {
    logic                      valid;
    logic [XLEN-1:0]           pc;
    mem_type_t                 mem_type;
    logic [2:0]                funct3;
    logic [REG_INDEX_BITS-1:0] rd;
    logic [REG_INDEX_BITS-1:0] rs1;
    logic [REG_INDEX_BITS-1:0] rs2;
    logic                      rd_valid;
    logic [XLEN-1:0]           imm;     // sign-extended
  } uop_t;

  typedef uop_t [FETCH_WIDTH-1:0] uop_bundle_t;

  // Per-slot lanes; the unused lane at an index stays zero
  typedef struct packed {
    uop_t [FETCH_WIDTH-1:0] int_lane;
    uop_t [FETCH_WIDTH-1:0] mem_lane;
  } dispatch_t;

endpackage

// ==== logic/fetch_latch.sv ====
/*
 * Fetch bundle input register
 * Drops bundles under back-pressure and qualifies each slot valid
 */
module fetch_latch (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  logic                        full,
  input  frontend_pkg::fetch_bundle_t bundle,
  input  logic                        bundle_valid,
  output frontend_pkg::fetch_bundle_t fetch_slots
);

  always_ff @(posedge clock) begin
    if (reset || flush || full) begin
      // Source holds its bundle while full, so nothing is lost here
      fetch_slots <= '0;
    end else begin
      for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
        fetch_slots[i].pc    <= bundle[i].pc;
        fetch_slots[i].inst  <= bundle[i].inst;
        fetch_slots[i].valid <= bundle_valid & bundle[i].valid;
      end
    end
  end

endmodule

// ==== logic/inst_decode.sv ====
/*
 * Combinational decode of each fetch slot into a micro-op
 * Handles OP, OP-IMM, LOAD, STORE and BRANCH; anything else becomes zero
 */
module inst_decode (
  input  frontend_pkg::fetch_bundle_t fetch_slots,
  output frontend_pkg::uop_bundle_t   decoded
);

  localparam int SEXT_BITS = frontend_pkg::XLEN - 12;

  always_comb begin
    frontend_pkg::inst_word_t inst;
    logic                     legal;

    decoded = '0;
    for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
      inst  = fetch_slots[i].inst;
      legal = 1'b1;

      case (inst.i_form.opcode)
        frontend_pkg::OPC_OP: begin
          decoded[i].mem_type = frontend_pkg::MEM_NONE;
          decoded[i].rd_valid = (inst.i_form.rd != '0);
          decoded[i].imm      = '0;
        end
        frontend_pkg::OPC_OP_IMM: begin
          decoded[i].mem_type = frontend_pkg::MEM_NONE;
          decoded[i].rd_valid = (inst.i_form.rd != '0);
          decoded[i].imm      = {{SEXT_BITS{inst.i_form.imm[11]}}, inst.i_form.imm};
        end
        frontend_pkg::OPC_LOAD: begin
          decoded[i].mem_type = frontend_pkg::MEM_LD;
          decoded[i].rd_valid = (inst.i_form.rd != '0);
          decoded[i].imm      = {{SEXT_BITS{inst.i_form.imm[11]}}, inst.i_form.imm};
        end
        frontend_pkg::OPC_STORE: begin
          // Immediate is split across the word in the S format
          decoded[i].mem_type = frontend_pkg::MEM_ST;
          decoded[i].rd_valid = 1'b0;
          decoded[i].imm      = {{SEXT_BITS{inst.s_form.imm_hi[6]}},
                                 inst.s_form.imm_hi, inst.s_form.imm_lo};
        end
        frontend_pkg::OPC_BRANCH: begin
          decoded[i].mem_type = frontend_pkg::MEM_NONE;
          decoded[i].rd_valid = 1'b0;
          decoded[i].imm      = '0;
        end
        default: begin
          legal = 1'b0;
        end
      endcase

      if (legal && fetch_slots[i].valid) begin
        decoded[i].valid  = 1'b1;
        decoded[i].pc     = fetch_slots[i].pc;
        decoded[i].funct3 = inst.i_form.funct3;
        decoded[i].rd     = inst.i_form.rd;
        decoded[i].rs1    = inst.i_form.rs1;
        // R-format rs2 sits at the same bits as the S-format field
        decoded[i].rs2    = inst.s_form.rs2;
      end else begin
        decoded[i] = '0;
      end
    end
  end

endmodule

// ==== logic/hold_stage.sv ====
/*
 * Stall-hold pipeline register
 * Captures its input on the first full cycle and replays it once full drops
 */
module hold_stage #(
  parameter int WIDTH = 1
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             flush,
  input  logic             full,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] held;
  logic             stall_prev;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      data_out   <= '0;
      held       <= '0;
      stall_prev <= 1'b0;
    end else if (full && !stall_prev) begin
      // First full cycle, keep what the previous stage offered
      data_out   <= '0;
      held       <= data_in;
      stall_prev <= 1'b1;
    end else if (full) begin
      data_out   <= '0;
    end else if (stall_prev) begin
      // Stall released, replay the held copy
      data_out   <= held;
      held       <= '0;
      stall_prev <= 1'b0;
    end else begin
      data_out   <= data_in;
    end
  end

endmodule

// ==== logic/dispatch_stage.sv ====
/*
 * Dispatch split into integer and memory lanes, followed by a hold register
 */
module dispatch_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      full,
  input  frontend_pkg::uop_bundle_t uops,
  output frontend_pkg::dispatch_t   dispatch
);

  localparam int DISPATCH_BITS = $bits(frontend_pkg::dispatch_t);

  frontend_pkg::dispatch_t routed;

  // Each slot keeps its index; only one lane carries it
  always_comb begin
    routed = '0;
    for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
      if (uops[i].mem_type == frontend_pkg::MEM_NONE) begin
        routed.int_lane[i] = uops[i];
      end else begin
        routed.mem_lane[i] = uops[i];
      end
    end
  end

  hold_stage #(
    .WIDTH (DISPATCH_BITS)
  ) u_hold_dispatch (
    .clock    (clock),
    .reset    (reset),
    .flush    (flush),
    .full     (full),
    .data_in  (routed),
    .data_out (dispatch)
  );

endmodule

// ==== logic/dispatch_frontend.sv ====
/*
 * Dispatch front end top: fetch latch, decode, decode hold stage and dispatch
 * Also forms the shared stall level from the downstream full inputs
 */
module dispatch_frontend (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  frontend_pkg::fetch_bundle_t bundle,
  input  logic                        bundle_valid,
  input  logic                        int_full,
  input  logic                        mem_full,
  output logic                        stall,
  output frontend_pkg::dispatch_t     dispatch
);

  localparam int UOP_BUNDLE_BITS = $bits(frontend_pkg::uop_bundle_t);

  logic                        full;
  frontend_pkg::fetch_bundle_t fetch_slots;
  frontend_pkg::uop_bundle_t   decoded;
  frontend_pkg::uop_bundle_t   renamed_free;

  // One level of back-pressure for every stage
  assign full  = int_full | mem_full;
  assign stall = full;

  fetch_latch u_fetch_latch (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .full         (full),
    .bundle       (bundle),
    .bundle_valid (bundle_valid),
    .fetch_slots  (fetch_slots)
  );

  inst_decode u_inst_decode (
    .fetch_slots (fetch_slots),
    .decoded     (decoded)
  );

  // Stage A, between decode and dispatch
  hold_stage #(
    .WIDTH (UOP_BUNDLE_BITS)
  ) u_hold_decode (
    .clock    (clock),
    .reset    (reset),
    .flush    (flush),
    .full     (full),
    .data_in  (decoded),
    .data_out (renamed_free)
  );

  dispatch_stage u_dispatch_stage (
    .clock    (clock),
    .reset    (reset),
    .flush    (flush),
    .full     (full),
    .uops     (renamed_free),
    .dispatch (dispatch)
  );

endmodule

// ==== include/frontend_tb_model.svh ====
/*
 * Testbench reference model: LFSR random source, instruction word
 * generators, expected decode and lane routing
 */
`ifndef FRONTEND_TB_MODEL_SVH
`define FRONTEND_TB_MODEL_SVH

localparam int KIND_OP      = 0;
localparam int KIND_OP_IMM  = 1;
localparam int KIND_LOAD    = 2;
localparam int KIND_STORE   = 3;
localparam int KIND_BRANCH  = 4;
localparam int KIND_ILLEGAL = 5;

logic [31:0] lfsr_state;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per returned bit
function automatic logic [31:0] rand_bits(int count);
  logic [31:0] value;
  logic        feedback;
  value = '0;
  for (int i = 0; i < count; i++) begin
    feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    value      = {value[30:0], feedback};
  end
  return value;
endfunction

function automatic logic is_legal_opcode(logic [6:0] opcode);
  return opcode == frontend_pkg::OPC_OP || opcode == frontend_pkg::OPC_OP_IMM ||
         opcode == frontend_pkg::OPC_LOAD || opcode == frontend_pkg::OPC_STORE ||
         opcode == frontend_pkg::OPC_BRANCH;
endfunction

// Random fields above the opcode, then the opcode of the requested class
function automatic logic [31:0] gen_word(int kind);
  logic [31:0] word;
  logic [6:0]  opcode;
  word = rand_bits(25) << 7;
  // Some writes to x0 so rd_valid takes both values
  if (rand_bits(3) == 0) word[11:7] = '0;
  case (kind)
    KIND_OP:     opcode = frontend_pkg::OPC_OP;
    KIND_OP_IMM: opcode = frontend_pkg::OPC_OP_IMM;
    KIND_LOAD:   opcode = frontend_pkg::OPC_LOAD;
    KIND_STORE:  opcode = frontend_pkg::OPC_STORE;
    KIND_BRANCH: opcode = frontend_pkg::OPC_BRANCH;
    default: begin
      opcode = 7'(rand_bits(7));
      // Bit 2 flipped turns each accepted opcode into an unused one
      if (is_legal_opcode(opcode)) opcode = opcode ^ 7'b0000100;
    end
  endcase
  word[6:0] = opcode;
  return word;
endfunction

function automatic frontend_pkg::uop_t model_decode(logic [31:0] pc, logic [31:0] word,
                                                    logic valid);
  frontend_pkg::uop_t uop;
  logic [31:0]        imm_i;
  logic [31:0]        imm_s;
  logic               rd_nonzero;
  uop        = '0;
  imm_i      = {{20{word[31]}}, word[31:20]};
  imm_s      = {{20{word[31]}}, word[31:25], word[11:7]};
  rd_nonzero = word[11:7] != 5'd0;
  if (!valid || !is_legal_opcode(word[6:0])) return uop;
  uop.valid  = 1'b1;
  uop.pc     = pc;
  uop.funct3 = word[14:12];
  uop.rd     = word[11:7];
  uop.rs1    = word[19:15];
  uop.rs2    = word[24:20];
  case (word[6:0])
    frontend_pkg::OPC_OP:     uop.rd_valid = rd_nonzero;
    frontend_pkg::OPC_OP_IMM: begin
      uop.rd_valid = rd_nonzero;
      uop.imm      = imm_i;
    end
    frontend_pkg::OPC_LOAD: begin
      uop.mem_type = frontend_pkg::MEM_LD;
      uop.rd_valid = rd_nonzero;
      uop.imm      = imm_i;
    end
    frontend_pkg::OPC_STORE: begin
      uop.mem_type = frontend_pkg::MEM_ST;
      uop.imm      = imm_s;
    end
    default: uop.rd_valid = 1'b0;
  endcase
  return uop;
endfunction

function automatic frontend_pkg::dispatch_t model_dispatch(frontend_pkg::fetch_bundle_t slots,
                                                           logic offered);
  frontend_pkg::dispatch_t result;
  frontend_pkg::uop_t      uop;
  result = '0;
  for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
    uop = model_decode(slots[i].pc, slots[i].inst, offered & slots[i].valid);
    if (uop.mem_type == frontend_pkg::MEM_NONE) result.int_lane[i] = uop;
    else result.mem_lane[i] = uop;
  end
  return result;
endfunction

// Integer lane valids low, memory lane valids high
function automatic logic [2*frontend_pkg::FETCH_WIDTH-1:0] lane_valids(
    frontend_pkg::dispatch_t d);
  logic [2*frontend_pkg::FETCH_WIDTH-1:0] v;
  for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
    v[i]                          = d.int_lane[i].valid;
    v[i+frontend_pkg::FETCH_WIDTH] = d.mem_lane[i].valid;
  end
  return v;
endfunction

`endif

// ==== tests/dispatch_frontend_tb.sv ====
/*
 * Testbench for the dispatch front end: clock, reset, random stimulus,
 * reference model queue, output checks and the final report
 */
module dispatch_frontend_tb;

  localparam logic [31:0] SEED          = 32'h56accab7;
  localparam int          RESET_CYCLES  = 2;
  localparam int          DRAIN_TIMEOUT = 200;
  localparam int          MODE_INT      = 0;
  localparam int          MODE_MEM      = 1;
  localparam int          MODE_DROP     = 2;
  localparam int          MODE_PRESSURE = 3;
  localparam int          MODE_FLUSH    = 4;

  logic                        clock;
  logic                        reset;
  logic                        flush;
  frontend_pkg::fetch_bundle_t bundle;
  logic                        bundle_valid;
  logic                        int_full;
  logic                        mem_full;
  logic                        stall;
  frontend_pkg::dispatch_t     dispatch;

  frontend_pkg::dispatch_t exp_queue[$];
  int                      exp_edge[$];
  int    edge_count;
  int    last_full_edge;
  logic  idle_edge;
  string test_name;
  int    test_errors;
  int    test_outputs;
  int    errors;
  int    checks;
  int    tests_run;
  int    tests_failed;

  `include "frontend_tb_model.svh"

  dispatch_frontend u_dispatch_frontend (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .bundle       (bundle),
    .bundle_valid (bundle_valid),
    .int_full     (int_full),
    .mem_full     (mem_full),
    .stall        (stall),
    .dispatch     (dispatch)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic check_value(string label, logic [511:0] expected, logic [511:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      test_errors++;
      $display("ERR %s %s: expected %0h actual %0h", test_name, label, expected, actual);
    end
  endtask

  function automatic int pick_kind(int mode);
    logic [31:0] r;
    if (mode == MODE_INT) begin
      r = rand_bits(2);
      return (r == 0) ? KIND_OP : (r == 1) ? KIND_BRANCH : KIND_OP_IMM;
    end
    if (mode == MODE_MEM) return (rand_bits(1) == 0) ? KIND_LOAD : KIND_STORE;
    r = rand_bits(3);
    return (r == 6) ? KIND_LOAD : (r == 7) ? KIND_OP_IMM : int'(r);
  endfunction

  // Called on the falling edge
  task automatic drive_inputs(int mode);
    logic hold;
    hold     = bundle_valid && stall;
    flush    = 1'b0;
    int_full = 1'b0;
    mem_full = 1'b0;
    if (mode >= MODE_PRESSURE) begin
      int_full = rand_bits(2) == 0;
      mem_full = rand_bits(2) == 0;
    end
    if (mode == MODE_FLUSH) flush = rand_bits(4) == 0;
    // The source keeps a bundle refused under back-pressure
    if (!hold) begin
      bundle_valid = rand_bits(2) != 0;
      for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
        bundle[i].pc = rand_bits(30) << 2;
        if (mode != MODE_DROP) begin
          bundle[i].inst  = gen_word(pick_kind(mode));
          bundle[i].valid = rand_bits(3) != 0;
        end else if (bundle_valid && rand_bits(1) == 1) begin
          bundle[i].inst  = gen_word(KIND_ILLEGAL);
          bundle[i].valid = 1'b1;
        end else begin
          // Dropped by bundle_valid or by the slot valid
          bundle[i].inst  = gen_word(pick_kind(MODE_PRESSURE));
          bundle[i].valid = !bundle_valid;
        end
      end
    end
  endtask

  // Model update on the rising edge, output check on the next falling edge
  task automatic step_cycle();
    frontend_pkg::dispatch_t                    expected;
    logic [$bits(frontend_pkg::dispatch_t)-1:0] exp_bits;
    logic [$bits(frontend_pkg::dispatch_t)-1:0] act_bits;
    logic                                       full_now;
    int                                         accept_edge;
    @(posedge clock);
    edge_count++;
    full_now = int_full | mem_full;
    check_value("stall", 512'(full_now), 512'(stall));
    if (reset || flush) begin
      exp_queue.delete();
      exp_edge.delete();
    end else if (bundle_valid && !full_now) begin
      expected = model_dispatch(bundle, bundle_valid);
      if (lane_valids(expected) != '0) begin
        exp_queue.push_back(expected);
        exp_edge.push_back(edge_count);
      end
    end
    if (full_now) last_full_edge = edge_count;
    idle_edge = full_now | reset | flush;

    @(negedge clock);
    if (idle_edge) check_value("idle lanes", 512'(0), 512'(lane_valids(dispatch)));
    if (lane_valids(dispatch) != '0) begin
      test_outputs++;
      if (exp_queue.size() == 0) begin
        errors++;
        test_errors++;
        $display("test %s: dispatch output at edge %0d with no bundle pending",
                 test_name, edge_count);
      end else begin
        expected    = exp_queue.pop_front();
        accept_edge = exp_edge.pop_front();
        exp_bits    = expected;
        act_bits    = dispatch;
        check_value("dispatch", 512'(exp_bits), 512'(act_bits));
        // Without back-pressure the path is exactly latch, stage A, stage B
        if (last_full_edge < accept_edge) begin
          check_value("latency", 512'(2), 512'(edge_count - accept_edge));
        end
      end
    end
  endtask

  task automatic drain();
    int waited;
    bundle_valid = 1'b0;
    int_full     = 1'b0;
    mem_full     = 1'b0;
    flush        = 1'b0;
    waited       = 0;
    while (exp_queue.size() != 0 && waited < DRAIN_TIMEOUT) begin
      step_cycle();
      waited++;
    end
    if (exp_queue.size() != 0) begin
      errors++;
      test_errors++;
      $display("test %s: timed out with %0d bundles never dispatched",
               test_name, exp_queue.size());
    end
    // A few idle cycles catch duplicates
    repeat (4) step_cycle();
  endtask

  task automatic start_test(string name);
    test_name    = name;
    test_errors  = 0;
    test_outputs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %s: %0d outputs checked, %0d errors, %s", test_name, test_outputs,
             test_errors, (test_errors == 0) ? "ok" : "FAILED");
  endtask

  task automatic run_test(string name, int mode, int cycles, logic silent);
    start_test(name);
    for (int c = 0; c < cycles; c++) begin
      drive_inputs(mode);
      step_cycle();
    end
    drain();
    if (silent) check_value("output count", 512'(0), 512'(test_outputs));
    end_test();
  endtask

  initial begin
    lfsr_state     = SEED;
    reset          = 1'b1;
    flush          = 1'b0;
    bundle         = '0;
    bundle_valid   = 1'b0;
    int_full       = 1'b0;
    mem_full       = 1'b0;
    edge_count     = 0;
    last_full_edge = -1;
    idle_edge      = 1'b0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_name      = "startup";
    repeat (RESET_CYCLES) step_cycle();
    reset = 1'b0;

    run_test("int_decode", MODE_INT, 200, 1'b0);
    run_test("mem_decode", MODE_MEM, 200, 1'b0);
    run_test("dropping", MODE_DROP, 150, 1'b1);
    run_test("back_pressure", MODE_PRESSURE, 400, 1'b0);
    run_test("flush", MODE_FLUSH, 400, 1'b0);

    // Reset in the middle of traffic, then fresh bundles
    start_test("reset");
    for (int c = 0; c < 30; c++) begin
      drive_inputs(MODE_PRESSURE);
      step_cycle();
    end
    reset = 1'b1;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      drive_inputs(MODE_PRESSURE);
      step_cycle();
    end
    reset = 1'b0;
    for (int c = 0; c < 40; c++) begin
      drive_inputs(MODE_INT);
      step_cycle();
    end
    drain();
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
logic/frontend_pkg.sv
logic/fetch_latch.sv
logic/inst_decode.sv
logic/hold_stage.sv
logic/dispatch_stage.sv
logic/dispatch_frontend.sv
tests/dispatch_frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module dispatch_frontend_tb \
  -Mdir obj_dir -o dispatch_frontend_sim || exit 1

sim_output="$(./obj_dir/dispatch_frontend_sim)"
echo "$sim_output"

echo "$sim_output" | grep -qx "Simulation passed" && exit 0 || exit 1
